// File: Makefile
TOP = esp_link_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f esp_link_top.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: esp_link_top.f
source/esp_link_pkg.sv
source/spi_link.sv
source/cmd_parser.sv
source/cmd_executor.sv
source/esp_link_top.sv
verification/esp_link_tb.sv

// File: source/cmd_executor.sv
`timescale 1ns/1ps

// runs fired commands against a local byte memory
module cmd_executor #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cmd_fire,
  input  esp_link_pkg::cmd_e cmd_op,
  input  logic [7:0]         p0,
  input  logic [7:0]         p1,
  input  logic [7:0]         p2,
  output logic [7:0]         resp_byte,
  output logic               resp_valid
);

  logic [7:0]            mem [2**MEM_ADDR_W];
  logic [15:0]           bus_addr;    // full 16 bit address from the esp
  logic [MEM_ADDR_W-1:0] addr;
  logic [7:0]            rd_data;     // registered read stage
  logic                  peek_pend;   // read in flight
  logic                  do_poke;
  logic                  do_peek;
  logic                  do_const;    // cookie or version

  assign bus_addr = {p1, p0};
  assign addr     = bus_addr[MEM_ADDR_W-1:0];   // upper bits alias

  assign do_poke  = cmd_fire && (cmd_op == esp_link_pkg::CMD_BRAM_POKE);
  assign do_peek  = cmd_fire && (cmd_op == esp_link_pkg::CMD_BRAM_PEEK);
  assign do_const = cmd_fire && (cmd_op == esp_link_pkg::CMD_GET_COOKIE ||
                                 cmd_op == esp_link_pkg::CMD_GET_VERSION);

  // single port memory
  always_ff @(posedge clk) begin
    if (do_poke) begin
      mem[addr] <= p2;
    end
    if (do_peek) begin
      rd_data <= mem[addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      peek_pend  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      peek_pend  <= do_peek;
      resp_valid <= peek_pend || do_const;   // peek one clk later than constants
    end
  end

  // response byte
  always_ff @(posedge clk) begin
    if (peek_pend) begin
      resp_byte <= rd_data;
    end else if (do_const) begin
      case (cmd_op)
        esp_link_pkg::CMD_GET_VERSION:
          resp_byte <= {esp_link_pkg::VERSION_MAJOR, esp_link_pkg::VERSION_MINOR};
        default: resp_byte <= esp_link_pkg::COOKIE;
      endcase
    end
  end

  // one response per command, never a burst
  a_resp_single : assert property (
    @(posedge clk) disable iff (!arst_n) resp_valid |=> !resp_valid
  );

endmodule

// File: source/cmd_parser.sv
`timescale 1ns/1ps

// collects opcode and parameter bytes, fires one strobe per command
module cmd_parser (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [7:0]         rx_byte,
  input  logic               rx_valid,
  input  logic               msg_start,
  output logic               cmd_fire,
  output esp_link_pkg::cmd_e cmd_op,
  output logic [7:0]         p0,
  output logic [7:0]         p1,
  output logic [7:0]         p2
);

  localparam int IDX_W = $clog2(esp_link_pkg::MAX_PARAMS);
  localparam int CNT_W = $clog2(esp_link_pkg::MAX_PARAMS + 1);

  esp_link_pkg::parser_state_e state;
  logic [IDX_W-1:0] idx;         // next buffer slot
  logic [CNT_W-1:0] remaining;   // params still expected
  logic [7:0]       params [esp_link_pkg::MAX_PARAMS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= esp_link_pkg::PS_IDLE;
      idx       <= '0;
      remaining <= '0;
      cmd_fire  <= 1'b0;
      cmd_op    <= esp_link_pkg::CMD_GET_COOKIE;
    end else begin
      cmd_fire <= 1'b0;
      if (msg_start) begin
        state <= esp_link_pkg::PS_IDLE;   // new frame always starts with an opcode
        idx   <= '0;
      end else if (rx_valid) begin
        case (state)
          esp_link_pkg::PS_IDLE: begin
            idx <= '0;
            case (rx_byte)
              esp_link_pkg::CMD_GET_COOKIE,
              esp_link_pkg::CMD_GET_VERSION: begin
                cmd_op   <= esp_link_pkg::cmd_e'(rx_byte);
                cmd_fire <= 1'b1;   // no params, fire right away
              end
              esp_link_pkg::CMD_BRAM_POKE: begin
                cmd_op    <= esp_link_pkg::CMD_BRAM_POKE;
                remaining <= CNT_W'(3);   // lo, hi, data
                state     <= esp_link_pkg::PS_READ_PARAMS;
              end
              esp_link_pkg::CMD_BRAM_PEEK: begin
                cmd_op    <= esp_link_pkg::CMD_BRAM_PEEK;
                remaining <= CNT_W'(2);   // lo, hi
                state     <= esp_link_pkg::PS_READ_PARAMS;
              end
              default: ;   // unknown opcode, ignored
            endcase
          end
          esp_link_pkg::PS_READ_PARAMS: begin
            remaining <= remaining - CNT_W'(1);
            if (remaining == CNT_W'(1)) begin
              cmd_fire <= 1'b1;
              idx      <= '0;
              state    <= esp_link_pkg::PS_IDLE;
            end else begin
              idx <= idx + IDX_W'(1);
            end
          end
          default: state <= esp_link_pkg::PS_IDLE;
        endcase
      end
    end
  end

  // parameter buffer
  always_ff @(posedge clk) begin
    if (rx_valid && !msg_start && state == esp_link_pkg::PS_READ_PARAMS) begin
      params[idx] <= rx_byte;
    end
  end

  assign p0 = params[0];
  assign p1 = params[1];
  assign p2 = params[2];

  a_idx_range : assert property (
    @(posedge clk) disable iff (!arst_n) int'(idx) < esp_link_pkg::MAX_PARAMS
  );

  // bytes are many clk apart so a command can never fire back to back
  a_fire_single : assert property (
    @(posedge clk) disable iff (!arst_n) cmd_fire |=> !cmd_fire
  );

endmodule

// File: source/esp_link_pkg.sv
// shared definitions for the esp command channel
package esp_link_pkg;

  // opcodes as sent by the esp, first byte of a message
  typedef enum logic [7:0] {
    CMD_GET_COOKIE  = 8'd0,   // returns COOKIE
    CMD_BRAM_POKE   = 8'd1,   // addr lo, addr hi, data
    CMD_BRAM_PEEK   = 8'd2,   // addr lo, addr hi
    CMD_GET_VERSION = 8'd15   // returns packed version
  } cmd_e;

  // parser FSM
  typedef enum logic [1:0] {
    PS_IDLE        = 2'd0,   // waiting for opcode
    PS_READ_PARAMS = 2'd1    // collecting parameter bytes
  } parser_state_e;

  // longest parameter list (poke)
  localparam int MAX_PARAMS = 3;

  // identification byte the esp looks for at boot
  localparam logic [7:0] COOKIE = 8'haf;

  // version byte is major in [7:5], minor in [4:0]
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

endpackage

// File: source/esp_link_top.sv
`timescale 1ns/1ps

// esp command channel, spi in, byte memory behind it
module esp_link_top #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]         rx_byte;
  logic               rx_valid;
  logic               msg_start;
  logic               cmd_fire;
  esp_link_pkg::cmd_e cmd_op;
  logic [7:0]         params [esp_link_pkg::MAX_PARAMS];   // lo addr, hi addr, data
  logic [7:0]         resp_byte;
  logic               resp_valid;

  spi_link i_spi_link (
    .clk        (clk),
    .arst_n     (arst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .msg_start  (msg_start),
    .resp_byte  (resp_byte),
    .resp_valid (resp_valid)
  );

  cmd_parser i_cmd_parser (
    .clk       (clk),
    .arst_n    (arst_n),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .msg_start (msg_start),
    .cmd_fire  (cmd_fire),
    .cmd_op    (cmd_op),
    .p0        (params[0]),
    .p1        (params[1]),
    .p2        (params[2])
  );

  cmd_executor #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) i_cmd_executor (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_fire   (cmd_fire),
    .cmd_op     (cmd_op),
    .p0         (params[0]),
    .p1         (params[1]),
    .p2         (params[2]),
    .resp_byte  (resp_byte),
    .resp_valid (resp_valid)
  );

endmodule

// File: source/spi_link.sv
`timescale 1ns/1ps

// spi slave, mode 0, msb first
// sck/cs_n/mosi are async to clk and get synchronized here
module spi_link (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       msg_start,
  input  logic [7:0] resp_byte,
  input  logic       resp_valid
);

  logic [2:0] sck_r;     // two sync stages plus one for edge detect
  logic [2:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;   // bits of current byte
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [3:0] tx_cnt;    // response bits still to go out

  logic sck_rise;
  logic cs_active;
  logic cs_fall;
  logic mosi_s;
  logic tx_busy;

  assign sck_rise  = sck_r[2:1] == 2'b01;
  assign cs_active = ~cs_r[1];
  assign cs_fall   = cs_r[2:1] == 2'b10;   // start of message
  assign mosi_s    = mosi_r[1];
  assign tx_busy   = tx_cnt != 4'd0;

  // input synchronizers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;   // deselected
      mosi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  // receive side
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt   <= 3'd0;
      rx_shift  <= 8'h00;
      rx_valid  <= 1'b0;
      msg_start <= 1'b0;
    end else begin
      msg_start <= cs_fall;
      // the dummy byte after a response is not a command byte
      rx_valid  <= cs_active && sck_rise && (bit_cnt == 3'd7) && !tx_busy;
      if (!cs_active) begin
        bit_cnt  <= 3'd0;   // resync on every frame
        rx_shift <= 8'h00;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_shift <= {rx_shift[6:0], mosi_s};
      end
    end
  end

  assign rx_byte = rx_shift;   // complete when rx_valid

  // transmit side
  // bit 7 sits on miso until the master samples it on its sck rise,
  // we shift a few clk later on the synchronized edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= 8'h00;
      tx_cnt   <= 4'd0;
    end else if (cs_fall) begin
      tx_shift <= 8'h00;   // drop whatever was pending
      tx_cnt   <= 4'd0;
    end else if (resp_valid) begin
      tx_shift <= resp_byte;
      tx_cnt   <= 4'd8;
    end else if (cs_active && sck_rise && tx_busy) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
      tx_cnt   <= tx_cnt - 4'd1;
    end
  end

  assign miso = cs_active & tx_shift[7];   // low when deselected

  // executor must only answer once the previous response is clocked out
  a_resp_not_busy : assert property (
    @(posedge clk) disable iff (!arst_n) resp_valid |-> !tx_busy
  );

endmodule

// File: verification/esp_link_tb.sv
`timescale 1ns/1ps

module esp_link_tb;

  localparam int HALF_SCK  = 6;                  // clk per sck level
  localparam int BYTE_CLKS = 2 * HALF_SCK * 8;
  localparam int FRAME_GAP = 8;                  // clk around cs_n edges
  localparam int RESP_WAIT = 16;                 // clk before the dummy byte
  localparam int RUN_BYTES  = 200;               // bytes over all tests, rounded up
  localparam int RUN_FRAMES = 50;
  // roughly twice the whole run
  localparam int TIMEOUT_CYCLES =
    2 * (RUN_BYTES * BYTE_CLKS + RUN_FRAMES * (3 * FRAME_GAP + RESP_WAIT));

  logic clk;
  logic arst_n;
  logic sck;
  logic cs_n;
  logic mosi;
  logic miso;

  int          mismatch_cnt;
  int          other_cnt;
  int          cycles;
  logic [7:0]  model [1024];   // host view of the byte memory

  esp_link_top #(
    .MEM_ADDR_W (10)
  ) i_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .miso   (miso)
  );

  always #4 clk = ~clk;   // 8 ns period

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      other_cnt = other_cnt + 1;
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // returns 1 ns after the n-th rising clk
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (got === exp) else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // mode 0 spi master, msb first, miso sampled as sck rises
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    rx = 8'h00;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];   // sck is low here
      wait_clks(HALF_SCK);
      rx[i] = miso;
      sck   = 1'b1;
      wait_clks(HALF_SCK);
      sck   = 1'b0;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [7:0] unused;
    spi_xfer(b, unused);
  endtask

  task automatic open_frame();
    cs_n = 1'b0;
    wait_clks(FRAME_GAP);   // msg_start settles before the first bit
  endtask

  task automatic close_frame();
    wait_clks(FRAME_GAP);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_clks(FRAME_GAP);
  endtask

  // single opcode message plus dummy byte
  task automatic request_const(input logic [7:0] op, output logic [7:0] op_miso,
                               output logic [7:0] resp);
    open_frame();
    spi_xfer(op, op_miso);
    wait_clks(RESP_WAIT);
    spi_xfer(8'h00, resp);
    close_frame();
  endtask

  task automatic poke(input logic [15:0] addr, input logic [7:0] data);
    open_frame();
    send_byte(esp_link_pkg::CMD_BRAM_POKE);
    send_byte(addr[7:0]);    // lo first
    send_byte(addr[15:8]);
    send_byte(data);
    close_frame();
    model[addr[9:0]] = data;   // address modulo 1024
  endtask

  task automatic peek(input logic [15:0] addr, output logic [7:0] data);
    open_frame();
    send_byte(esp_link_pkg::CMD_BRAM_PEEK);
    send_byte(addr[7:0]);
    send_byte(addr[15:8]);
    wait_clks(RESP_WAIT);
    spi_xfer(8'h00, data);   // dummy byte carries the answer
    close_frame();
  endtask

  task automatic test_get_cookie();
    logic [7:0] op_miso;
    logic [7:0] resp;
    request_const(esp_link_pkg::CMD_GET_COOKIE, op_miso, resp);
    check_byte("miso cookie", esp_link_pkg::COOKIE, resp);
  endtask

  task automatic test_get_version();
    logic [7:0] op_miso;
    logic [7:0] resp;
    request_const(esp_link_pkg::CMD_GET_VERSION, op_miso, resp);
    check_byte("miso during opcode", 8'h00, op_miso);   // nothing pending yet
    check_byte("miso version", 8'h03, resp);            // major 0, minor 3
  endtask

  task automatic test_poke_peek();
    logic [31:0] rnd;
    logic [15:0] addrs [20];
    logic [7:0]  got;
    for (int k = 0; k < 20; k++) begin
      rnd      = $urandom();
      addrs[k] = rnd[15:0];    // full 16 bits, upper ones alias
      poke(addrs[k], rnd[23:16]);
    end
    for (int k = 0; k < 20; k++) begin
      peek(addrs[k], got);
      check_byte("miso peek data", model[addrs[k][9:0]], got);   // last write wins
    end
  endtask

  task automatic test_alias();
    logic [7:0] got;
    poke(16'h0405, 8'h5a);
    peek(16'h0005, got);   // bit 10 dropped by the memory
    check_byte("miso alias peek", 8'h5a, got);
  endtask

  task automatic test_abort_unknown();
    logic [7:0] op_miso;
    logic [7:0] got;
    open_frame();
    send_byte(esp_link_pkg::CMD_BRAM_POKE);
    send_byte(8'h05);
    close_frame();         // cut before addr hi and data
    peek(16'h0005, got);
    check_byte("miso peek after abort", model[5], got);
    // unknown opcode right before a cookie request in one frame
    open_frame();
    send_byte(8'h63);      // not an opcode
    spi_xfer(esp_link_pkg::CMD_GET_COOKIE, op_miso);
    wait_clks(RESP_WAIT);
    spi_xfer(8'h00, got);
    close_frame();
    check_byte("miso after unknown opcode", 8'h00, op_miso);   // no answer to it
    check_byte("miso cookie after unknown", esp_link_pkg::COOKIE, got);
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    sck          = 1'b0;
    cs_n         = 1'b1;
    mosi         = 1'b0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    cycles       = 0;
    void'($urandom(88909));
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    wait_clks(4);

    test_get_cookie();
    test_get_version();
    test_poke_peek();
    test_alias();
    test_abort_unknown();

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
